// File: Bender.yml
package:
  name: vector_cfg

export_include_dirs:
  - include

sources:
  # packages first, top level last
  - include_dirs:
      - include
    files:
      - src/vec_types_pkg.sv
      - src/csr_types_pkg.sv
      - src/vsetvl_unit.sv
      - src/vector_csr.sv
      - src/csr_access.sv
      - src/vector_cfg_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/vector_cfg_checker.sv
      - dv/vector_cfg_tb.sv

// File: dv/vector_cfg_checker.sv
// --------------------
// concurrent assertions for the vector configuration block
// bound to vector_cfg_top from the testbench
// failures also counted in assert_fails for the final report
// --------------------

`timescale 1ns/100ps

`include "vec_params.svh"

module vector_cfg_checker (
    input logic                  CLK,
    input logic                  nRST,
    input logic                  csr_valid,
    input logic                  csr_illegal,
    input logic [`XLEN-1:0]      vl,
    input vec_types_pkg::vtype_u vtype,
    input logic [`VSTART_W-1:0]  vstart
);

    // read hierarchically by the testbench at the end of the run
    int unsigned assert_fails = 0;

    // first edge after reset release still sees the cleared state
    reset_clear: assert property (@(posedge CLK)
        $rose(nRST) |-> (vl == '0) && (vtype.raw == '0) && (vstart == '0) && !csr_illegal)
        else begin
            assert_fails++;
            $error("vl, vtype, vstart or csr_illegal not cleared by reset");
        end

    // illegal flag only qualifies a real access
    illegal_needs_valid: assert property (@(posedge CLK) disable iff (!nRST)
        csr_illegal |-> csr_valid)
        else begin
            assert_fails++;
            $error("csr_illegal high without csr_valid");
        end

    // vill forces vl to zero
    vill_zero_vl: assert property (@(posedge CLK) disable iff (!nRST)
        vtype.f.vill |-> (vl == '0))
        else begin
            assert_fails++;
            $error("vtype.vill set with nonzero vl");
        end

    // LMUL 8 at SEW 8 is the largest group, VLEN elements
    vl_in_range: assert property (@(posedge CLK) disable iff (!nRST)
        vl <= `XLEN'(`VLEN))
        else begin
            assert_fails++;
            $error("vl above VLEN");
        end

endmodule

// File: dv/vector_cfg_tb.sv
// --------------------
// testbench for vector_cfg_top
// random and directed vset, trap, done and CSR pulses
// a reference model mirrors the state and is compared every cycle
// outputs sampled on the falling edge, inputs change 1 ns after rising
// --------------------

`timescale 1ns/100ps

`include "vec_params.svh"

module vector_cfg_tb;

    localparam int N_VSET      = 300;
    localparam int N_TRAP      = 120;
    localparam int N_CSR       = 200;
    localparam int N_MIX       = 200;
    // reset cycles and directed ops included with some slack
    localparam int N_OPS       = 16 + 60 + N_VSET + N_TRAP + N_CSR + N_MIX;
    localparam int WATCHDOG_NS = N_OPS * 8 + 1000;
    localparam int DRIVE_DLY   = 1;

    logic                     CLK;
    logic                     nRST;
    logic                     vset;
    logic [`XLEN-1:0]         avl;
    vec_types_pkg::vtype_u    new_vtype;
    logic                     rs1_zero;
    logic                     rd_zero;
    logic                     csr_valid;
    logic [11:0]              csr_addr;
    csr_types_pkg::csr_op_e   csr_op;
    logic [`XLEN-1:0]         csr_operand;
    logic                     trap;
    logic [`VSTART_W-1:0]     trap_elem;
    logic                     vinstr_done;
    logic [`XLEN-1:0]         rd_value;
    logic [`XLEN-1:0]         csr_rdata;
    logic                     csr_illegal;
    logic [`XLEN-1:0]         vl;
    vec_types_pkg::vtype_u    vtype;
    logic [`VSTART_W-1:0]     vstart;

    // mirrored state
    logic [`XLEN-1:0]         m_vl;
    logic [`XLEN-1:0]         m_vtype;
    logic [`VSTART_W-1:0]     m_vstart;

    logic [31:0]              rng = 32'h2f7d;
    int unsigned              errors = 0;
    int unsigned              checks = 0;

    vector_cfg_top vector_cfg_top_inst (
        .CLK         (CLK),
        .nRST        (nRST),
        .vset        (vset),
        .avl         (avl),
        .new_vtype   (new_vtype),
        .rs1_zero    (rs1_zero),
        .rd_zero     (rd_zero),
        .csr_valid   (csr_valid),
        .csr_addr    (csr_addr),
        .csr_op      (csr_op),
        .csr_operand (csr_operand),
        .trap        (trap),
        .trap_elem   (trap_elem),
        .vinstr_done (vinstr_done),
        .rd_value    (rd_value),
        .csr_rdata   (csr_rdata),
        .csr_illegal (csr_illegal),
        .vl          (vl),
        .vtype       (vtype),
        .vstart      (vstart)
    );

    bind vector_cfg_top vector_cfg_checker vector_cfg_checker_inst (
        .CLK         (CLK),
        .nRST        (nRST),
        .csr_valid   (csr_valid),
        .csr_illegal (csr_illegal),
        .vl          (vl),
        .vtype       (vtype),
        .vstart      (vstart)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // LCG, upper half folded down since the low bits cycle quickly
    function automatic logic [31:0] next_rand();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng ^ (rng >> 16);
    endfunction

    // expected outputs for the current inputs, and the state after the edge
    function automatic void ref_model(output logic [31:0] exp_rd,
                                      output logic [31:0] exp_rdata,
                                      output logic        exp_illegal,
                                      output logic [31:0] nxt_vl,
                                      output logic [31:0] nxt_vtype,
                                      output logic [`VSTART_W-1:0] nxt_vstart);
        logic [31:0] vt;
        logic [31:0] vlmax;
        logic [31:0] vset_vl;
        logic [31:0] vset_vt;
        logic [31:0] wval;
        logic        bad_vt;
        logic        known;
        logic        writes;
        int unsigned sew;
        int unsigned lmul_num;
        int unsigned lmul_den;
        vt  = new_vtype.raw;
        sew = 8 << vt[5:3];
        lmul_num = 1;
        lmul_den = 1;
        case (vt[2:0])
            3'd1: lmul_num = 2;
            3'd2: lmul_num = 4;
            3'd3: lmul_num = 8;
            3'd4: lmul_num = 0;
            3'd5: lmul_den = 8;
            3'd6: lmul_den = 4;
            3'd7: lmul_den = 2;
            default: lmul_num = 1;
        endcase
        // SEW above ELEN also covers the reserved SEW codes
        bad_vt = vt[31] || (vt[30:8] != 0) || (sew > `ELEN) || (lmul_num == 0)
               || ((lmul_den > 1) && (sew * lmul_den > `ELEN));
        vlmax = bad_vt ? 0 : (`VLEN * lmul_num) / (sew * lmul_den);
        if (bad_vt) begin
            vset_vl = 0;
            vset_vt = 32'h8000_0000;
        end else if (rs1_zero && rd_zero) begin
            vset_vl = m_vl;
            vset_vt = vt;
        end else if (rs1_zero) begin
            vset_vl = vlmax;
            vset_vt = vt;
        end else begin
            vset_vl = (avl < vlmax) ? avl : vlmax;
            vset_vt = vt;
        end
        exp_rd = vset_vl;
        // CSR read side
        known     = 1'b1;
        exp_rdata = 0;
        case (csr_addr)
            12'h008: exp_rdata = 32'(m_vstart);
            12'hC20: exp_rdata = m_vl;
            12'hC21: exp_rdata = m_vtype;
            12'hC22: exp_rdata = `VLEN / 8;
            default: known = 1'b0;
        endcase
        writes = ((csr_op == csr_types_pkg::SET) || (csr_op == csr_types_pkg::CLEAR))
               ? (csr_operand != 0) : 1'b1;
        exp_illegal = csr_valid && (!known || (writes && (csr_addr != 12'h008)));
        case (csr_op)
            csr_types_pkg::SET:   wval = exp_rdata | csr_operand;
            csr_types_pkg::CLEAR: wval = exp_rdata & ~csr_operand;
            default:              wval = csr_operand;
        endcase
        // one winner per cycle, highest priority first
        nxt_vl     = m_vl;
        nxt_vtype  = m_vtype;
        nxt_vstart = m_vstart;
        if (vset) begin
            nxt_vl    = vset_vl;
            nxt_vtype = vset_vt;
        end else if (trap) begin
            if (trap_elem > m_vstart) nxt_vstart = trap_elem;
        end else if (vinstr_done) begin
            nxt_vstart = 0;
        end else if (csr_valid && writes && (csr_addr == 12'h008)) begin
            nxt_vstart = wval[`VSTART_W-1:0];
        end
    endfunction

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    // compare on the falling edge, then advance the mirror
    always @(negedge CLK) begin
        logic [31:0]          e_rd;
        logic [31:0]          e_rdata;
        logic                 e_ill;
        logic [31:0]          n_vl;
        logic [31:0]          n_vt;
        logic [`VSTART_W-1:0] n_vs;
        if (!nRST) begin
            m_vl     = 0;
            m_vtype  = 0;
            m_vstart = 0;
        end else begin
            ref_model(e_rd, e_rdata, e_ill, n_vl, n_vt, n_vs);
            compare_word("vl", vl, m_vl);
            compare_word("vtype", vtype.raw, m_vtype);
            compare_word("vstart", 32'(vstart), 32'(m_vstart));
            compare_word("rd_value", rd_value, e_rd);
            compare_word("csr_rdata", csr_rdata, e_rdata);
            compare_word("csr_illegal", 32'(csr_illegal), 32'(e_ill));
            m_vl     = n_vl;
            m_vtype  = n_vt;
            m_vstart = n_vs;
        end
    end

    task automatic clear_inputs();
        vset        = 1'b0;
        avl         = '0;
        new_vtype   = '0;
        rs1_zero    = 1'b0;
        rd_zero     = 1'b0;
        csr_valid   = 1'b0;
        csr_addr    = '0;
        csr_op      = csr_types_pkg::WRITE;
        csr_operand = '0;
        trap        = 1'b0;
        trap_elem   = '0;
        vinstr_done = 1'b0;
    endtask

    // each op owns exactly one cycle
    task automatic next_cycle();
        @(posedge CLK);
        #(DRIVE_DLY);
        clear_inputs();
    endtask

    task automatic apply_vset(input logic [31:0] vt, input logic [31:0] a,
                              input logic rs1z, input logic rdz);
        next_cycle();
        vset          = 1'b1;
        new_vtype.raw = vt;
        avl           = a;
        rs1_zero      = rs1z;
        rd_zero       = rdz;
    endtask

    task automatic apply_csr(input logic [11:0] addr, input csr_types_pkg::csr_op_e op,
                             input logic [31:0] operand);
        next_cycle();
        csr_valid   = 1'b1;
        csr_addr    = addr;
        csr_op      = op;
        csr_operand = operand;
    endtask

    function automatic csr_types_pkg::csr_op_e pick_op(input logic [1:0] sel);
        case (sel)
            2'd0:    return csr_types_pkg::WRITE;
            2'd1:    return csr_types_pkg::SET;
            default: return csr_types_pkg::CLEAR;
        endcase
    endfunction

    // the seven vector addresses, otherwise any 12-bit value
    function automatic logic [11:0] pick_addr(input logic [31:0] r);
        case (r[3:0])
            4'd0, 4'd7: return 12'h008;
            4'd1:       return 12'h009;
            4'd2:       return 12'h00A;
            4'd3:       return 12'h00F;
            4'd4:       return 12'hC20;
            4'd5:       return 12'hC21;
            4'd6:       return 12'hC22;
            default:    return r[27:16];
        endcase
    endfunction

    // mostly legal SEW, sometimes reserved bits or vill from rs2
    function automatic logic [31:0] random_vtype();
        logic [31:0] r;
        logic [31:0] vt;
        r  = next_rand();
        vt = {24'h0, r[7:0]};
        if (r[20]) vt[5] = 1'b0;
        if (r[31:28] == 4'h0) vt[8 + (r[13:9] % 23)] = 1'b1;
        if (r[27:24] == 4'h0) vt[31] = 1'b1;
        return vt;
    endfunction

    function automatic logic [31:0] random_avl();
        logic [31:0] r;
        r = next_rand();
        return (r[1:0] == 2'd0) ? next_rand() : (next_rand() % 300);
    endfunction

    // any combination of pulses in one cycle
    task automatic apply_random_mix();
        logic [31:0] r;
        logic [31:0] vt;
        logic [31:0] a;
        r  = next_rand();
        vt = random_vtype();
        a  = random_avl();
        next_cycle();
        vset          = r[0];
        new_vtype.raw = vt;
        avl           = a;
        rs1_zero      = r[1];
        rd_zero       = r[2];
        trap          = r[3];
        trap_elem     = r[15:8];
        vinstr_done   = r[4];
        csr_valid     = r[5];
        csr_addr      = r[6] ? 12'h008 : pick_addr(next_rand());
        csr_op        = pick_op(r[17:16]);
        csr_operand   = r[18] ? '0 : next_rand();
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] r;
        int unsigned asserts;
        clear_inputs();
        nRST = 1'b0;
        repeat (16) @(posedge CLK);
        #(DRIVE_DLY);
        nRST = 1'b1;
        // reset values seen through plain reads
        apply_csr(12'h008, csr_types_pkg::SET, '0);
        apply_csr(12'hC20, csr_types_pkg::SET, '0);
        apply_csr(12'hC21, csr_types_pkg::CLEAR, '0);
        apply_csr(12'hC22, csr_types_pkg::SET, '0);
        // corner vsets, x0 forms and fractional limits
        apply_vset(32'h0000_0003, 32'd1000, 1'b0, 1'b0);
        apply_vset(32'h0000_0015, 32'd5, 1'b1, 1'b0);
        apply_vset(32'h0000_00D0, 32'd7, 1'b1, 1'b1);
        apply_vset(32'h0000_0017, 32'd3, 1'b0, 1'b0);
        apply_vset(32'h0000_0018, 32'd3, 1'b0, 1'b0);
        apply_vset(32'h0000_0004, 32'd3, 1'b1, 1'b1);
        for (int i = 0; i < N_VSET; i++) begin
            r = next_rand();
            apply_vset(random_vtype(), random_avl(), r[0], r[1]);
        end
        // vstart only moves up on a trap
        for (int i = 0; i < N_TRAP; i++) begin
            r = next_rand();
            next_cycle();
            if (r[2:0] == 3'd0) vinstr_done = 1'b1;
            else trap = 1'b1;
            trap_elem = r[15:8];
        end
        // read-modify-write on vstart, masked to its width
        apply_csr(12'h008, csr_types_pkg::WRITE, 32'hFFFF_FF5A);
        apply_csr(12'h008, csr_types_pkg::CLEAR, 32'h0000_000F);
        apply_csr(12'h008, csr_types_pkg::SET, 32'h1234_0081);
        apply_csr(12'hC20, csr_types_pkg::WRITE, 32'h0000_0004);
        apply_csr(12'hC21, csr_types_pkg::SET, 32'h0000_0001);
        apply_csr(12'hC22, csr_types_pkg::CLEAR, 32'h0000_0010);
        apply_csr(12'h009, csr_types_pkg::SET, '0);
        apply_csr(12'h00A, csr_types_pkg::WRITE, '0);
        apply_csr(12'h00F, csr_types_pkg::CLEAR, '0);
        apply_csr(12'h7C0, csr_types_pkg::SET, '0);
        for (int i = 0; i < N_CSR; i++) begin
            r = next_rand();
            apply_csr(pick_addr(next_rand()), pick_op(r[1:0]), r[2] ? '0 : next_rand());
        end
        // simultaneous and back-to-back pulses
        for (int i = 0; i < N_MIX; i++) begin
            apply_random_mix();
        end
        next_cycle();
        repeat (3) @(posedge CLK);
        asserts = vector_cfg_top_inst.vector_cfg_checker_inst.assert_fails;
        $display("checks: %0d  errors: %0d  assertion failures: %0d", checks, errors, asserts);
        if ((errors == 0) && (asserts == 0)) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: include/vec_params.svh
// --------------------
// sizing macros for the vector configuration block
// include in any file that needs register or vector widths
// VLEN may be set to 64, 128 or 256
// --------------------

`ifndef VEC_PARAMS_SVH
`define VEC_PARAMS_SVH

// scalar register width
`define XLEN 32

// vector register length in bits
`define VLEN 128

// widest supported element
`define ELEN 32

// element index width, one extra bit so LMUL 8 at SEW 8 fits
`define VSTART_W ($clog2(`VLEN) + 1)

`endif

// File: sources.f
+incdir+include
src/vec_types_pkg.sv
src/csr_types_pkg.sv
src/vsetvl_unit.sv
src/vector_csr.sv
src/csr_access.sv
src/vector_cfg_top.sv
dv/vector_cfg_checker.sv
dv/vector_cfg_tb.sv

// File: src/csr_access.sv
// --------------------
// Zicsr front end for the vector CSRs
// builds the read-modify-write value from the current read
// and decides whether the access is legal
// only vstart accepts writes
// --------------------

`timescale 1ns/100ps

`include "vec_params.svh"

module csr_access (
    input  logic                     csr_valid,
    input  logic [11:0]              csr_addr,
    input  csr_types_pkg::csr_op_e   csr_op,
    input  logic [`XLEN-1:0]         csr_operand,
    input  logic [`XLEN-1:0]         csr_rdata,
    input  logic                     csr_hit,
    output csr_types_pkg::csr_addr_e csr_addr_sel,
    output logic                     csr_write,
    output logic [`XLEN-1:0]         csr_wdata,
    output logic                     csr_illegal
);

    logic wr_req;
    logic wr_ok;

    // address goes straight to the read mux
    assign csr_addr_sel = csr_types_pkg::csr_addr_e'(csr_addr);

    // set/clear with a zero operand is a plain read
    always_comb begin
        case (csr_op)
            csr_types_pkg::SET:   wr_req = |csr_operand;
            csr_types_pkg::CLEAR: wr_req = |csr_operand;
            default:              wr_req = 1'b1;
        endcase
    end

    // new value from the old one
    always_comb begin
        case (csr_op)
            csr_types_pkg::SET:   csr_wdata = csr_rdata | csr_operand;
            csr_types_pkg::CLEAR: csr_wdata = csr_rdata & ~csr_operand;
            default:              csr_wdata = csr_operand;
        endcase
    end

    // vl, vtype and vlenb are read only
    assign wr_ok = csr_hit & (csr_addr_sel == csr_types_pkg::VSTART);

    assign csr_write = csr_valid & wr_req & wr_ok;

    // unknown or unimplemented address, or a write to a read-only CSR
    assign csr_illegal = csr_valid & (~csr_hit | (wr_req & ~wr_ok));

endmodule

// File: src/csr_types_pkg.sv
// --------------------
// Zicsr side of the vector CSRs
// addresses and the read-modify-write op codes
// referenced as csr_types_pkg::name
// --------------------

package csr_types_pkg;

    // vector CSR addresses
    // vxsat, vxrm and vcsr are listed so they can be
    // recognised, but no storage exists for them
    typedef enum logic [11:0] {
        VSTART = 12'h008,
        VXSAT  = 12'h009,
        VXRM   = 12'h00A,
        VCSR   = 12'h00F,
        VL     = 12'hC20,
        VTYPE  = 12'hC21,
        VLENB  = 12'hC22
    } csr_addr_e;

    // follows the low two funct3 bits of csrrw/csrrs/csrrc
    // and their immediate forms
    typedef enum logic [1:0] {
        WRITE = 2'b01,
        SET   = 2'b10,
        CLEAR = 2'b11
    } csr_op_e;

endpackage

// File: src/vec_types_pkg.sv
// --------------------
// vector configuration types
// vtype layout plus SEW and LMUL codes
// referenced as vec_types_pkg::name
// --------------------

`include "vec_params.svh"

package vec_types_pkg;

    // element width codes, 1xx reserved
    typedef enum logic [2:0] {
        SEW_8  = 3'b000,
        SEW_16 = 3'b001,
        SEW_32 = 3'b010,
        SEW_64 = 3'b011
    } vsew_e;

    // group multiplier codes, 100 reserved
    typedef enum logic [2:0] {
        LMUL_1   = 3'b000,
        LMUL_2   = 3'b001,
        LMUL_4   = 3'b010,
        LMUL_8   = 3'b011,
        LMUL_1_8 = 3'b101,
        LMUL_1_4 = 3'b110,
        LMUL_1_2 = 3'b111
    } vlmul_e;

    // field view of vtype, vill sits in the top bit
    typedef struct packed {
        logic        vill;
        logic [22:0] reserved;
        logic        vma;
        logic        vta;
        vsew_e       vsew;
        vlmul_e      vlmul;
    } vtype_fields_t;

    // raw word for CSR reads, fields for decode
    typedef union packed {
        logic [`XLEN-1:0] raw;
        vtype_fields_t    f;
    } vtype_u;

endpackage

// File: src/vector_cfg_top.sv
// --------------------
// vector configuration block top level
// connects the vsetvl logic, the CSR state and the
// Zicsr front end to the core side ports
// all requests are single-cycle pulses
// --------------------

`timescale 1ns/100ps

`include "vec_params.svh"

module vector_cfg_top (
    input  logic                   CLK,
    input  logic                   nRST,
    // vset pulse
    input  logic                   vset,
    input  logic [`XLEN-1:0]       avl,
    input  vec_types_pkg::vtype_u  new_vtype,
    input  logic                   rs1_zero,
    input  logic                   rd_zero,
    // CSR access pulse
    input  logic                   csr_valid,
    input  logic [11:0]            csr_addr,
    input  csr_types_pkg::csr_op_e csr_op,
    input  logic [`XLEN-1:0]       csr_operand,
    // trap and completion
    input  logic                   trap,
    input  logic [`VSTART_W-1:0]   trap_elem,
    input  logic                   vinstr_done,
    // results
    output logic [`XLEN-1:0]       rd_value,
    output logic [`XLEN-1:0]       csr_rdata,
    output logic                   csr_illegal,
    output logic [`XLEN-1:0]       vl,
    output vec_types_pkg::vtype_u  vtype,
    output logic [`VSTART_W-1:0]   vstart
);

    logic [`XLEN-1:0]         set_vl;
    logic                     keep_vl;
    vec_types_pkg::vtype_u    legal_vtype;
    csr_types_pkg::csr_addr_e csr_addr_sel;
    logic                     csr_write;
    logic [`XLEN-1:0]         csr_wdata;
    logic                     csr_hit;

    vsetvl_unit vsetvl_unit_inst (
        .new_vtype   (new_vtype),
        .avl         (avl),
        .rs1_zero    (rs1_zero),
        .rd_zero     (rd_zero),
        .cur_vl      (vl),
        .set_vl      (set_vl),
        .keep_vl     (keep_vl),
        .legal_vtype (legal_vtype),
        .rd_value    (rd_value)
    );

    vector_csr vector_csr_inst (
        .CLK          (CLK),
        .nRST         (nRST),
        .vset         (vset),
        .set_vl       (set_vl),
        .keep_vl      (keep_vl),
        .legal_vtype  (legal_vtype),
        .trap         (trap),
        .trap_elem    (trap_elem),
        .vinstr_done  (vinstr_done),
        .csr_addr_sel (csr_addr_sel),
        .csr_write    (csr_write),
        .csr_wdata    (csr_wdata),
        .csr_rdata    (csr_rdata),
        .csr_hit      (csr_hit),
        .vl           (vl),
        .vtype        (vtype),
        .vstart       (vstart)
    );

    csr_access csr_access_inst (
        .csr_valid    (csr_valid),
        .csr_addr     (csr_addr),
        .csr_op       (csr_op),
        .csr_operand  (csr_operand),
        .csr_rdata    (csr_rdata),
        .csr_hit      (csr_hit),
        .csr_addr_sel (csr_addr_sel),
        .csr_write    (csr_write),
        .csr_wdata    (csr_wdata),
        .csr_illegal  (csr_illegal)
    );

endmodule

// File: src/vector_csr.sv
// --------------------
// vstart, vl and vtype state
// one update per cycle, chosen by priority
// vset > trap > vinstr_done > CSR write of vstart
// reads are combinational by address, vlenb is a constant
// --------------------

`timescale 1ns/100ps

`include "vec_params.svh"

module vector_csr (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     vset,
    input  logic [`XLEN-1:0]         set_vl,
    input  logic                     keep_vl,
    input  vec_types_pkg::vtype_u    legal_vtype,
    input  logic                     trap,
    input  logic [`VSTART_W-1:0]     trap_elem,
    input  logic                     vinstr_done,
    input  csr_types_pkg::csr_addr_e csr_addr_sel,
    input  logic                     csr_write,
    input  logic [`XLEN-1:0]         csr_wdata,
    output logic [`XLEN-1:0]         csr_rdata,
    output logic                     csr_hit,
    output logic [`XLEN-1:0]         vl,
    output vec_types_pkg::vtype_u    vtype,
    output logic [`VSTART_W-1:0]     vstart
);

    logic [`VSTART_W-1:0]  vstart_next;
    logic [`XLEN-1:0]      vl_next;
    vec_types_pkg::vtype_u vtype_next;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            vstart <= '0;
            vl     <= '0;
            vtype  <= '0;
        end else begin
            vstart <= vstart_next;
            vl     <= vl_next;
            vtype  <= vtype_next;
        end
    end

    // lower priority sources are simply dropped in the same cycle
    always_comb begin
        vstart_next = vstart;
        vl_next     = vl;
        vtype_next  = vtype;
        if (vset) begin
            vtype_next = legal_vtype;
            if (!keep_vl) begin
                vl_next = set_vl;
            end
        end else if (trap) begin
            // a fault during restart may report an element below vstart,
            // keep the furthest point reached
            if (trap_elem > vstart) begin
                vstart_next = trap_elem;
            end
        end else if (vinstr_done) begin
            vstart_next = '0;
        end else if (csr_write && (csr_addr_sel == csr_types_pkg::VSTART)) begin
            // upper bits of the write are dropped
            vstart_next = csr_wdata[`VSTART_W-1:0];
        end
    end

    // read mux, hit marks an implemented address
    always_comb begin
        csr_rdata = '0;
        csr_hit   = 1'b0;
        case (csr_addr_sel)
            csr_types_pkg::VSTART: begin
                csr_rdata = `XLEN'(vstart);
                csr_hit   = 1'b1;
            end
            csr_types_pkg::VL: begin
                csr_rdata = vl;
                csr_hit   = 1'b1;
            end
            csr_types_pkg::VTYPE: begin
                csr_rdata = vtype.raw;
                csr_hit   = 1'b1;
            end
            csr_types_pkg::VLENB: begin
                // register length in bytes
                csr_rdata = `XLEN'(`VLEN / 8);
                csr_hit   = 1'b1;
            end
            default: begin
                csr_rdata = '0;
                csr_hit   = 1'b0;
            end
        endcase
    end

endmodule

// File: src/vsetvl_unit.sv
// --------------------
// vsetvl/vsetvli/vsetivli result logic
// purely combinational, sampled by vector_csr on vset
// gives the new vl, the vtype to store and the rd value
// --------------------

`timescale 1ns/100ps

`include "vec_params.svh"

module vsetvl_unit (
    input  vec_types_pkg::vtype_u new_vtype,
    input  logic [`XLEN-1:0]      avl,
    input  logic                  rs1_zero,
    input  logic                  rd_zero,
    input  logic [`XLEN-1:0]      cur_vl,
    output logic [`XLEN-1:0]      set_vl,
    output logic                  keep_vl,
    output vec_types_pkg::vtype_u legal_vtype,
    output logic [`XLEN-1:0]      rd_value
);

    logic [`XLEN-1:0] sew_bits;
    logic [`XLEN-1:0] elen_frac;
    logic [`XLEN-1:0] vlmax_base;
    logic [`XLEN-1:0] vlmax;
    logic             lmul_frac;
    logic             lmul_rsvd;
    logic [1:0]       lmul_shift;
    logic             illegal;

    // element width in bits is 8 << code
    assign sew_bits = `XLEN'(8) << new_vtype.f.vsew;

    // VLEN/SEW gives one register worth of elements
    assign vlmax_base = `XLEN'(`VLEN) >> (3 + new_vtype.f.vsew);

    // split LMUL into direction and shift amount
    always_comb begin
        lmul_frac  = 1'b0;
        lmul_rsvd  = 1'b0;
        lmul_shift = 2'd0;
        case (new_vtype.f.vlmul)
            vec_types_pkg::LMUL_1:   lmul_shift = 2'd0;
            vec_types_pkg::LMUL_2:   lmul_shift = 2'd1;
            vec_types_pkg::LMUL_4:   lmul_shift = 2'd2;
            vec_types_pkg::LMUL_8:   lmul_shift = 2'd3;
            vec_types_pkg::LMUL_1_8: begin
                lmul_frac  = 1'b1;
                lmul_shift = 2'd3;
            end
            vec_types_pkg::LMUL_1_4: begin
                lmul_frac  = 1'b1;
                lmul_shift = 2'd2;
            end
            vec_types_pkg::LMUL_1_2: begin
                lmul_frac  = 1'b1;
                lmul_shift = 2'd1;
            end
            default: lmul_rsvd = 1'b1;
        endcase
    end

    // largest SEW allowed for a fractional group is ELEN*LMUL
    assign elen_frac = `XLEN'(`ELEN) >> lmul_shift;

    // any reserved bit, vill from rs2 included, makes it unsupported
    assign illegal = new_vtype.f.vill
                   | (|new_vtype.f.reserved)
                   | new_vtype.f.vsew[2]
                   | (sew_bits > `XLEN'(`ELEN))
                   | lmul_rsvd
                   | (lmul_frac & (sew_bits > elen_frac));

    assign vlmax = lmul_frac ? (vlmax_base >> lmul_shift) : (vlmax_base << lmul_shift);

    // an illegal vtype must still force vl to zero, so no keep then
    assign keep_vl = rs1_zero & rd_zero & ~illegal;

    always_comb begin
        if (illegal) begin
            set_vl = '0;
        end else if (rs1_zero) begin
            // rs1 = x0 with rd != x0 requests VLMAX
            set_vl = vlmax;
        end else begin
            set_vl = (avl < vlmax) ? avl : vlmax;
        end
    end

    // on illegal only vill survives
    always_comb begin
        legal_vtype = new_vtype;
        if (illegal) begin
            legal_vtype        = '0;
            legal_vtype.f.vill = 1'b1;
        end
    end

    assign rd_value = keep_vl ? cur_vl : set_vl;

endmodule
